/* cc_pkg.sv */
// cc_pkg: widths, row and lane types and the register map of the parity-protected cache RAM
`default_nettype none

package cc_pkg;

  localparam int DATA_W   = 32;
  localparam int LANES    = 4;
  localparam int LANE_W   = 9;  // data byte plus even parity
  localparam int ROW_W    = LANES * LANE_W;
  localparam int ADDR_W   = 6;
  localparam int DEPTH    = 64;
  localparam int ERRCNT_W = 16;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [LANES-1:0]    ben_t;
  // lane i at [9i +: 9], parity in the top bit of each lane
  typedef logic [ROW_W-1:0]    row_t;

  typedef logic [7:0]          apb_addr_t;
  typedef logic [31:0]         apb_data_t;
  typedef logic [ERRCNT_W-1:0] errcnt_t;

  // register map
  localparam apb_addr_t REG_CTRL   = 8'h00;
  localparam apb_addr_t REG_STATUS = 8'h04;
  localparam apb_addr_t REG_ERRCNT = 8'h08;

endpackage

`default_nettype wire

/* cc_wr_if.sv */
// cc_wr_if: one row write, lane enables included, from the write path into the RAM bank
`timescale 1ns/1ns
`default_nettype none

interface cc_wr_if;
  import cc_pkg::*;

  logic  wen;
  addr_t addr;
  row_t  row;      // lanes already carry their parity
  ben_t  lane_en;

  modport src (
    output wen,
    output addr,
    output row,
    output lane_en
  );

  modport dst (
    input wen,
    input addr,
    input row,
    input lane_en
  );

endinterface

`default_nettype wire

/* cc_ctl_if.sv */
// cc_ctl_if: control bits and parity error events between the register block and the datapath
`timescale 1ns/1ns
`default_nettype none

interface cc_ctl_if;

  logic check_en;
  logic inject;
  logic init_busy;
  logic err_a;     // single-cycle events
  logic err_b;

  modport regs (
    output check_en,
    output inject,
    input  init_busy,
    input  err_a,
    input  err_b
  );

  modport dp_wr (
    input  inject,
    output init_busy
  );

  modport dp_rd (
    input  check_en,
    output err_a,
    output err_b
  );

endinterface

`default_nettype wire

/* cc_regs.sv */
// cc_regs: APB block for control, init and sticky error status, and the parity error counter
`timescale 1ns/1ns
`default_nettype none

module cc_regs (
  input  logic              clk,
  input  logic              rst,
  input  cc_pkg::apb_addr_t paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  cc_pkg::apb_data_t pwdata,
  output cc_pkg::apb_data_t prdata,
  output logic              pready,
  output logic              pslverr,
  cc_ctl_if.regs            ctl
);
  import cc_pkg::*;

  logic                access;
  logic                mapped;
  logic                wr_ctrl;
  logic                wr_status;
  logic                wr_errcnt;
  logic                check_en;
  logic                inject;
  logic                sticky_a;
  logic                sticky_b;
  errcnt_t             errcnt;
  logic [1:0]          inc;
  logic [ERRCNT_W:0]   sum;

  assign access    = psel & penable;
  assign mapped    = paddr inside {REG_CTRL, REG_STATUS, REG_ERRCNT};
  assign wr_ctrl   = access & pwrite & (paddr == REG_CTRL);
  assign wr_status = access & pwrite & (paddr == REG_STATUS);
  assign wr_errcnt = access & pwrite & (paddr == REG_ERRCNT);

  assign pready  = 1'b1;  // zero wait states
  assign pslverr = access & ~mapped;

  always_comb begin
    case (paddr)
      REG_CTRL:   prdata = {30'b0, inject, check_en};
      REG_STATUS: prdata = {29'b0, sticky_b, sticky_a, ctl.init_busy};
      REG_ERRCNT: prdata = apb_data_t'(errcnt);
      default:    prdata = '0;
    endcase
  end

  // both ports may fire in the same cycle
  assign inc = {1'b0, ctl.err_a} + {1'b0, ctl.err_b};
  assign sum = errcnt + inc;

  always_ff @(posedge clk) begin
    if (rst) begin
      check_en <= 1'b0;
      inject   <= 1'b0;
      sticky_a <= 1'b0;
      sticky_b <= 1'b0;
      errcnt   <= '0;
    end else begin
      if (wr_ctrl) begin
        check_en <= pwdata[0];
        inject   <= pwdata[1];
      end
      // new event beats a write-one-to-clear in the same cycle
      sticky_a <= ctl.err_a | (sticky_a & ~(wr_status & pwdata[1]));
      sticky_b <= ctl.err_b | (sticky_b & ~(wr_status & pwdata[2]));
      if (wr_errcnt) errcnt <= errcnt_t'(inc);
      else if (sum[ERRCNT_W]) errcnt <= '1;  // saturate
      else errcnt <= sum[ERRCNT_W-1:0];
    end
  end

  assign ctl.check_en = check_en;
  assign ctl.inject   = inject;

endmodule

`default_nettype wire

/* cc_write_path.sv */
// cc_write_path: post-reset clear sweep, registered user writes with parity and error injection
`timescale 1ns/1ns
`default_nettype none

module cc_write_path (
  input  logic          clk,
  input  logic          rst,
  input  logic          wr_en,
  input  cc_pkg::addr_t wr_addr,
  input  cc_pkg::data_t wr_data,
  input  cc_pkg::ben_t  wr_ben,
  cc_wr_if.src          wr,
  cc_ctl_if.dp_wr       ctl
);
  import cc_pkg::*;

  logic  init_busy;
  addr_t init_cnt;
  logic  wen_q;
  addr_t addr_q;
  row_t  row_q;
  ben_t  ben_q;
  row_t  row_new;

  always_comb begin
    for (int i = 0; i < LANES; i++) begin
      row_new[i*LANE_W +: LANE_W-1] = wr_data[i*(LANE_W-1) +: LANE_W-1];
      // even parity, flipped while injecting
      row_new[i*LANE_W + LANE_W-1] = ^wr_data[i*(LANE_W-1) +: LANE_W-1] ^ ctl.inject;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      init_cnt  <= '0;
    end else if (init_busy) begin
      init_cnt <= init_cnt + 1'b1;
      if (init_cnt == addr_t'(DEPTH-1)) init_busy <= 1'b0;  // last row cleared
    end
  end

  always_ff @(posedge clk) begin
    if (rst) wen_q <= 1'b0;
    else wen_q <= wr_en & ~init_busy;  // user writes dropped during sweep
  end

  always_ff @(posedge clk) begin
    addr_q <= wr_addr;
    row_q  <= row_new;
    ben_q  <= wr_ben;
  end

  // all-zero row is already even parity
  assign wr.wen     = init_busy | wen_q;
  assign wr.addr    = init_busy ? init_cnt : addr_q;
  assign wr.row     = init_busy ? '0 : row_q;
  assign wr.lane_en = init_busy ? '1 : ben_q;

  assign ctl.init_busy = init_busy;

endmodule

`default_nettype wire

/* cc_bank.sv */
// cc_bank: 64-row RAM with per-lane write enables and two registered-address read ports
`timescale 1ns/1ns
`default_nettype none

module cc_bank (
  input  logic          clk,
  input  logic          rst,
  cc_wr_if.dst          wr,
  input  logic          a_en,
  input  logic          b_en,
  input  cc_pkg::addr_t a_addr,
  input  cc_pkg::addr_t b_addr,
  output cc_pkg::row_t  a_row,
  output cc_pkg::row_t  b_row
);
  import cc_pkg::*;

  row_t  mem [DEPTH];
  addr_t a_addr_q;
  addr_t b_addr_q;

  // read addresses only move on a strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      a_addr_q <= '0;
      b_addr_q <= '0;
    end else begin
      if (a_en) a_addr_q <= a_addr;
      if (b_en) b_addr_q <= b_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (wr.wen) begin
      for (int i = 0; i < LANES; i++) begin
        if (wr.lane_en[i]) begin
          mem[wr.addr][i*LANE_W +: LANE_W] <= wr.row[i*LANE_W +: LANE_W];
        end
      end
    end
  end

  // row follows the latched address, so a later write shows up here too
  assign a_row = mem[a_addr_q];
  assign b_row = mem[b_addr_q];

endmodule

`default_nettype wire

/* cc_read_check.sv */
// cc_read_check: strips parity from both read ports and flags odd-parity lanes after each read
`timescale 1ns/1ns
`default_nettype none

module cc_read_check (
  input  logic          clk,
  input  logic          rst,
  input  logic          a_en,
  input  logic          b_en,
  input  cc_pkg::row_t  a_row,
  input  cc_pkg::row_t  b_row,
  output cc_pkg::data_t a_data,
  output cc_pkg::data_t b_data,
  output logic          a_err,
  output logic          b_err,
  cc_ctl_if.dp_rd       ctl
);
  import cc_pkg::*;

  logic a_en_q;
  logic b_en_q;

  function automatic data_t strip(input row_t r);
    data_t d;
    for (int i = 0; i < LANES; i++) begin
      d[i*(LANE_W-1) +: LANE_W-1] = r[i*LANE_W +: LANE_W-1];
    end
    return d;
  endfunction

  // any lane whose 9 bits xor to one
  function automatic logic bad_parity(input row_t r);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < LANES; i++) begin
      bad = bad | (^r[i*LANE_W +: LANE_W]);
    end
    return bad;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      a_en_q <= 1'b0;
      b_en_q <= 1'b0;
    end else begin
      a_en_q <= a_en;
      b_en_q <= b_en;
    end
  end

  assign a_data = strip(a_row);
  assign b_data = strip(b_row);

  assign a_err = a_en_q & ctl.check_en & bad_parity(a_row);  // first cycle only
  assign b_err = b_en_q & ctl.check_en & bad_parity(b_row);

  assign ctl.err_a = a_err;
  assign ctl.err_b = b_err;

endmodule

`default_nettype wire

/* cc_ram_top.sv */
// cc_ram_top: parity-protected dual-read cache data RAM with its APB register block alongside
`timescale 1ns/1ns
`default_nettype none

module cc_ram_top (
  input  logic              clk,
  input  logic              rst,
  input  cc_pkg::apb_addr_t paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  cc_pkg::apb_data_t pwdata,
  output cc_pkg::apb_data_t prdata,
  output logic              pready,
  output logic              pslverr,
  input  logic              wr_en,
  input  cc_pkg::addr_t     wr_addr,
  input  cc_pkg::data_t     wr_data,
  input  cc_pkg::ben_t      wr_ben,
  input  logic              a_en,
  input  cc_pkg::addr_t     a_addr,
  output cc_pkg::data_t     a_data,
  output logic              a_err,
  input  logic              b_en,
  input  cc_pkg::addr_t     b_addr,
  output cc_pkg::data_t     b_data,
  output logic              b_err
);
  import cc_pkg::*;

  row_t a_row;  // raw rows, parity still attached
  row_t b_row;

  cc_wr_if  wr_bus ();
  cc_ctl_if ctl_bus ();

  cc_regs u_regs (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .ctl     (ctl_bus)
  );

  cc_write_path u_write_path (
    .clk     (clk),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_ben  (wr_ben),
    .wr      (wr_bus),
    .ctl     (ctl_bus)
  );

  cc_bank u_bank (
    .clk    (clk),
    .rst    (rst),
    .wr     (wr_bus),
    .a_en   (a_en),
    .b_en   (b_en),
    .a_addr (a_addr),
    .b_addr (b_addr),
    .a_row  (a_row),
    .b_row  (b_row)
  );

  cc_read_check u_read_check (
    .clk    (clk),
    .rst    (rst),
    .a_en   (a_en),
    .b_en   (b_en),
    .a_row  (a_row),
    .b_row  (b_row),
    .a_data (a_data),
    .b_data (b_data),
    .a_err  (a_err),
    .b_err  (b_err),
    .ctl    (ctl_bus)
  );

endmodule

`default_nettype wire

/* cc_ram_props.sv */
// cc_ram_props: bound checks on the APB handshake and the parity error outputs of the RAM
`timescale 1ns/1ns
`default_nettype none

module cc_ram_props (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic a_err,
  input logic b_err
);

  int fail_count = 0;

  pready_high: assert property (@(posedge clk) pready)
    else begin
      fail_count++;
      $error("pready went low");
    end

  // only inside an access phase
  pslverr_in_access: assert property (@(posedge clk) pslverr |-> psel && penable)
    else begin
      fail_count++;
      $error("pslverr raised outside an APB access");
    end

  err_quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !a_err && !b_err)
    else begin
      fail_count++;
      $error("parity error output high during reset");
    end

endmodule

bind cc_ram_top cc_ram_props u_props (
  .clk     (clk),
  .rst     (rst),
  .psel    (psel),
  .penable (penable),
  .pready  (pready),
  .pslverr (pslverr),
  .a_err   (a_err),
  .b_err   (b_err)
);

`default_nettype wire

/* tb_cc_ram.sv */
// tb_cc_ram: directed testbench for the parity-protected dual-read cache RAM and its APB block
`timescale 1ns/1ns
`default_nettype none

module tb_cc_ram;
  import cc_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int RST_CYCLES = 10;
  // cycle budget of each test
  localparam int CYC_INIT   = 120;
  localparam int CYC_LANES  = 200;
  localparam int CYC_INJECT = 60;
  localparam int CYC_OFF    = 40;
  localparam int CYC_APB    = 40;
  localparam int CYC_TOTAL  = RST_CYCLES + CYC_INIT + CYC_LANES + CYC_INJECT + CYC_OFF
                              + CYC_APB;

  localparam addr_t BAD_ROW  = 6'd40;
  localparam addr_t GOOD_ROW = 6'd41;

  logic      clk;
  logic      rst;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      wr_en;
  addr_t     wr_addr;
  data_t     wr_data;
  ben_t      wr_ben;
  logic      a_en;
  addr_t     a_addr;
  data_t     a_data;
  logic      a_err;
  logic      b_en;
  addr_t     b_addr;
  data_t     b_data;
  logic      b_err;

  int          checks;
  int          errors;
  string       test_name;
  logic [31:0] lfsr;
  data_t       model [DEPTH];  // expected row contents

  cc_ram_top u_dut (.*);

  always #(CLK_PERIOD/2) clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic compare_data(input string label, input data_t exp, input data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, label, exp, act);
    end
  endtask

  task automatic compare_reg(input string label, input apb_data_t exp, input apb_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED [%s] %s: expected %h, actual %h", test_name, label, exp, act);
    end
  endtask

  task automatic compare_bit(input string label, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED [%s] %s: expected %b, actual %b", test_name, label, exp, act);
    end
  endtask

  // setup then access phase, sampled mid-cycle
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    paddr   = addr;
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD/4);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_access(1'b0, addr, '0, data, err);
  endtask

  // extra idle cycle so a following read lands two edges later
  task automatic ram_write(input addr_t addr, input data_t data, input ben_t ben);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    wr_ben  = ben;
    @(negedge clk);
    wr_en = 1'b0;
    @(negedge clk);
  endtask

  task automatic ram_read(input logic use_a, input addr_t addr_a, input logic use_b,
                          input addr_t addr_b, output data_t da, output logic ea,
                          output data_t db, output logic eb);
    a_en   = use_a;
    a_addr = addr_a;
    b_en   = use_b;
    b_addr = addr_b;
    @(negedge clk);
    a_en = 1'b0;
    b_en = 1'b0;
    #(CLK_PERIOD/4);  // err is only valid in this cycle
    da = a_data;
    ea = a_err;
    db = b_data;
    eb = b_err;
    @(negedge clk);
  endtask

  task automatic sweep_clears_rows();
    apb_data_t rd;
    logic      err;
    data_t     da;
    data_t     db;
    logic      ea;
    logic      eb;
    int        cycles;
    test_name = "init_sweep";
    cycles = 0;
    rd = 32'h1;
    while (rd[0] && cycles < 70) begin
      apb_read(REG_STATUS, rd, err);
      cycles += 2;
    end
    if (rd[0]) begin
      errors++;
      $display("[%s] init_busy still high 70 cycles after reset", test_name);
    end
    apb_write(REG_CTRL, 32'h1, err);  // checking on
    for (int r = 0; r < DEPTH; r += 21) begin
      ram_read(1'b1, addr_t'(r), 1'b1, addr_t'(DEPTH-1-r), da, ea, db, eb);
      compare_data("port a cleared", '0, da);
      compare_data("port b cleared", '0, db);
      compare_bit("a_err", 1'b0, ea);
      compare_bit("b_err", 1'b0, eb);
    end
  endtask

  task automatic lane_writes_merge();
    addr_t wa;
    addr_t rb;
    data_t wd;
    ben_t  be;
    data_t da;
    data_t db;
    logic  ea;
    logic  eb;
    test_name = "lane_writes";
    for (int n = 0; n < 16; n++) begin
      wa = addr_t'(rand_bits(3));  // few rows, so lanes merge
      wd = rand_bits(DATA_W);
      be = ben_t'(rand_bits(LANES));
      ram_write(wa, wd, be);
      for (int i = 0; i < LANES; i++) begin
        if (be[i]) model[wa][i*8 +: 8] = wd[i*8 +: 8];
      end
      rb = addr_t'(rand_bits(3));
      ram_read(1'b1, wa, 1'b1, rb, da, ea, db, eb);
      compare_data("port a merged", model[wa], da);
      compare_data("port b merged", model[rb], db);
      compare_bit("a_err", 1'b0, ea);
      compare_bit("b_err", 1'b0, eb);
    end
  endtask

  task automatic parity_inject();
    apb_data_t rd;
    logic      err;
    data_t     da;
    data_t     db;
    logic      ea;
    logic      eb;
    test_name = "inject";
    apb_write(REG_ERRCNT, '0, err);
    apb_write(REG_STATUS, 32'h6, err);
    apb_write(REG_CTRL, 32'h3, err);
    ram_write(BAD_ROW, 32'hA5C3_0F11, 4'hF);
    apb_write(REG_CTRL, 32'h1, err);
    ram_write(GOOD_ROW, 32'h1234_5678, 4'hF);
    ram_read(1'b1, BAD_ROW, 1'b0, GOOD_ROW, da, ea, db, eb);
    compare_bit("bad row a_err", 1'b1, ea);
    compare_data("bad row data", 32'hA5C3_0F11, da);
    ram_read(1'b1, GOOD_ROW, 1'b0, GOOD_ROW, da, ea, db, eb);
    compare_bit("good row a_err", 1'b0, ea);
    compare_data("good row data", 32'h1234_5678, da);
    // both ports flag in the same cycle, counter steps by two
    ram_read(1'b1, BAD_ROW, 1'b1, BAD_ROW, da, ea, db, eb);
    compare_bit("dual bad a_err", 1'b1, ea);
    compare_bit("bad row b_err", 1'b1, eb);
    apb_read(REG_ERRCNT, rd, err);
    compare_reg("errcnt", 32'd3, rd);
    apb_read(REG_STATUS, rd, err);
    compare_reg("sticky bits", 32'h6, rd);
  endtask

  task automatic check_disabled();
    apb_data_t rd;
    logic      err;
    data_t     da;
    data_t     db;
    logic      ea;
    logic      eb;
    test_name = "check_off";
    apb_write(REG_CTRL, '0, err);
    ram_read(1'b1, BAD_ROW, 1'b1, BAD_ROW, da, ea, db, eb);
    compare_bit("a_err", 1'b0, ea);
    compare_bit("b_err", 1'b0, eb);
    apb_read(REG_ERRCNT, rd, err);
    compare_reg("errcnt held", 32'd3, rd);
    apb_write(REG_STATUS, 32'h6, err);
    apb_read(REG_STATUS, rd, err);
    compare_reg("sticky cleared", '0, rd);
    apb_write(REG_ERRCNT, 32'hFFFF, err);
    apb_read(REG_ERRCNT, rd, err);
    compare_reg("errcnt cleared", '0, rd);
  endtask

  task automatic apb_error_responses();
    apb_data_t rd;
    logic      err;
    test_name = "apb_errors";
    apb_read(8'h0C, rd, err);
    compare_bit("read pslverr", 1'b1, err);
    compare_reg("unmapped read", '0, rd);
    apb_write(8'h10, 32'h3, err);
    compare_bit("write pslverr", 1'b1, err);
    apb_read(REG_CTRL, rd, err);
    compare_bit("ctrl pslverr", 1'b0, err);
    compare_reg("ctrl untouched", '0, rd);
    apb_write(REG_STATUS, 32'h1, err);
    apb_read(REG_STATUS, rd, err);
    compare_reg("init_busy kept", '0, rd);
  endtask

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    wr_ben  = '0;
    a_en    = 1'b0;
    a_addr  = '0;
    b_en    = 1'b0;
    b_addr  = '0;
    checks  = 0;
    errors  = 0;
    lfsr    = 32'd87497;
    test_name = "reset";
    foreach (model[i]) model[i] = '0;
    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    sweep_clears_rows();
    lane_writes_merge();
    parity_inject();
    check_disabled();
    apb_error_responses();
    $display("checks %0d, check errors %0d, assertion failures %0d",
             checks, errors, u_dut.u_props.fail_count);
    if (errors == 0 && u_dut.u_props.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(CYC_TOTAL * CLK_PERIOD);
    $display("watchdog expired, run took longer than %0d cycles", CYC_TOTAL);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
cc_pkg.sv
cc_wr_if.sv
cc_ctl_if.sv
cc_regs.sv
cc_write_path.sv
cc_bank.sv
cc_read_check.sv
cc_ram_top.sv
cc_ram_props.sv
tb_cc_ram.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cache RAM testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_cc_ram -f files.f -o sim_tb
./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log

if grep -q "TB PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
